// ==== common/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// pc and memory address width, one word per location
`define CPU_ADDR_W 11

`define CPU_NREGS  16  // general registers, all ordinary

`define CPU_DATA_W 32

`endif

// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_EOR,
        ALU_MOV,
        ALU_CMP
    } alu_op_e;

    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC,
        COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT,
        COND_GT, COND_LE, COND_AL,
        COND_HALT = 4'b1111  // stops the core
    } cond_e;

    typedef enum logic [1:0] {SH_LSL, SH_LSR, SH_ASR, SH_ROR} shift_e;

    // instruction class, bits 27..26
    localparam logic [1:0] CLS_DP  = 2'b00;
    localparam logic [1:0] CLS_MEM = 2'b01;
    localparam logic [1:0] CLS_BR  = 2'b10;

    // next pc source
    localparam logic [1:0] PC_SEL_START = 2'd0;
    localparam logic [1:0] PC_SEL_INC   = 2'd1;
    localparam logic [1:0] PC_SEL_BR    = 2'd2;

    // NZCV positions in the status word
    localparam int ST_N = 31;
    localparam int ST_Z = 30;
    localparam int ST_C = 29;
    localparam int ST_V = 28;

    typedef struct packed {
        logic [4:0] imm5;
        shift_e     shift_op;
        logic       zero;
        logic [3:0] rm;
    } op2_reg_t;

    // second operand, immediate or shifted register
    typedef union packed {
        logic [11:0] imm12;
        op2_reg_t    rs;
    } op2_u;

    typedef struct packed {
        cond_e      cond;
        logic [1:0] cls;
        logic       i;
        alu_op_e    opcode;
        logic       s;
        logic       rsvd;
        logic [3:0] rn;
        logic [3:0] rd;
        op2_u       op2;
    } dp_fmt_t;

    typedef struct packed {
        cond_e       cond;
        logic [1:0]  cls;
        logic        p;
        logic        u;
        logic [1:0]  zero;
        logic        w;
        logic        l;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [11:0] imm12;
    } mem_fmt_t;

    typedef struct packed {
        cond_e       cond;
        logic [1:0]  cls;
        logic [1:0]  zero;
        logic [23:0] imm24;  // signed word offset
    } br_fmt_t;

    typedef union packed {
        dp_fmt_t  dp;
        mem_fmt_t mem;
        br_fmt_t  br;
    } instr_u;

endpackage

`default_nettype wire

// ==== datapath/alu_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cpu_settings.svh"

module alu_shifter (
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    input  logic [4:0]             imm5,
    input  cpu_pkg::shift_e        shift_op,
    input  logic                   use_shift,
    input  cpu_pkg::alu_op_e       alu_op,
    input  logic [3:0]             flags_in,  // NZCV
    output logic [`CPU_DATA_W-1:0] result,
    output logic [3:0]             flags_out
);
    import cpu_pkg::*;

    localparam int W = `CPU_DATA_W;

    logic [W-1:0] b_sh;
    logic [W:0]   sum;
    logic         c, v;

    always_comb begin
        b_sh = b;
        if (use_shift) begin
            case (shift_op)
                SH_LSL: b_sh = b << imm5;
                SH_LSR: b_sh = b >> imm5;
                SH_ASR: b_sh = $signed(b) >>> imm5;
                SH_ROR: b_sh = (b >> imm5) | (b << (W - int'(imm5)));  // zero amount gives b
                default: b_sh = b;
            endcase
        end
    end

    always_comb begin
        c = flags_in[1];  // logic ops keep C and V
        v = flags_in[0];
        case (alu_op)
            ALU_ADD: begin
                sum = {1'b0, a} + {1'b0, b_sh};
                c   = sum[W];
                v   = (a[W-1] == b_sh[W-1]) && (sum[W-1] != a[W-1]);
            end
            ALU_SUB, ALU_CMP: begin
                sum = {1'b0, a} + {1'b0, ~b_sh} + (W+1)'(1);
                c   = sum[W];  // set when no borrow
                v   = (a[W-1] != b_sh[W-1]) && (sum[W-1] != a[W-1]);
            end
            ALU_AND: sum = {1'b0, a & b_sh};
            ALU_ORR: sum = {1'b0, a | b_sh};
            ALU_EOR: sum = {1'b0, a ^ b_sh};
            default: sum = {1'b0, b_sh};
        endcase
        result    = sum[W-1:0];
        flags_out = {result[W-1], result == '0, c, v};
    end

endmodule

`default_nettype wire

// ==== datapath/datapath.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cpu_settings.svh"

module datapath (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`CPU_ADDR_W-1:0]        start_pc,
    input  logic                          load_pc,
    input  logic [1:0]                    sel_pc,
    input  logic [$clog2(`CPU_NREGS)-1:0] rn,
    input  logic [$clog2(`CPU_NREGS)-1:0] rd,
    input  logic [$clog2(`CPU_NREGS)-1:0] rm,
    input  logic [4:0]                    imm5,
    input  cpu_pkg::shift_e               shift_op,
    input  logic [`CPU_DATA_W-1:0]        imm12,
    input  logic [23:0]                   imm24,
    input  cpu_pkg::alu_op_e              alu_op,
    input  logic                          en_a,
    input  logic                          en_b,
    input  logic                          en_c,
    input  logic                          sel_b_imm,
    input  logic                          sel_pre_indexed,
    input  logic                          en_status,
    input  logic                          w_en1,
    input  logic                          w_en_ldr,
    input  logic                          w_en_base,
    input  logic [`CPU_DATA_W-1:0]        ram_data2,
    input  logic [$clog2(`CPU_NREGS)-1:0] reg_addr,
    output logic [`CPU_ADDR_W-1:0]        pc_out,
    output logic [`CPU_DATA_W-1:0]        datapath_out,
    output logic [`CPU_ADDR_W-1:0]        ram_addr2,
    output logic [`CPU_DATA_W-1:0]        ram_in2,
    output logic [`CPU_DATA_W-1:0]        status_out,
    output logic [`CPU_DATA_W-1:0]        reg_output
);
    import cpu_pkg::*;

    localparam int DW = `CPU_DATA_W;
    localparam int AW = `CPU_ADDR_W;

    logic [DW-1:0] regs [`CPU_NREGS];
    logic [DW-1:0] a_reg, b_reg, c_reg, str_data, status_reg;
    logic [DW-1:0] b_op, result;
    logic [3:0]    flags;
    logic [AW-1:0] pc, pc_inc;

    assign pc_inc = pc + 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (load_pc) begin
            case (sel_pc)
                PC_SEL_START: pc <= start_pc;
                PC_SEL_BR:    pc <= pc_inc + imm24[AW-1:0];  // wraps in AW bits
                default:      pc <= pc_inc;
            endcase
        end
    end

    // single write port, ldr and base writeback come in later cycles
    always_ff @(posedge clk) begin
        if (w_en1) begin
            regs[rd] <= result;
        end else if (w_en_ldr) begin
            regs[rd] <= ram_data2;
        end else if (w_en_base) begin
            regs[rn] <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (en_a) begin
            a_reg <= regs[rn];
        end
        if (en_b) begin
            b_reg    <= regs[rm];
            str_data <= regs[rd];
        end
        if (en_c) begin
            c_reg <= sel_pre_indexed ? result : a_reg;  // alu result or memory address
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_reg <= '0;
        end else if (en_status) begin
            status_reg[ST_N -: 4] <= flags;
        end
    end

    assign b_op = sel_b_imm ? imm12 : b_reg;

    alu_shifter i_alu_shifter (
        .a         (a_reg),
        .b         (b_op),
        .imm5      (imm5),
        .shift_op  (shift_op),
        .use_shift (!sel_b_imm),
        .alu_op    (alu_op),
        .flags_in  (status_reg[ST_N -: 4]),
        .result    (result),
        .flags_out (flags)
    );

    assign pc_out       = pc;
    assign datapath_out = c_reg;
    assign ram_addr2    = c_reg[AW-1:0];
    assign ram_in2      = str_data;
    assign status_out   = status_reg;
    assign reg_output   = regs[reg_addr];  // debug read

endmodule

`default_nettype wire

// ==== controller/controller.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cpu_settings.svh"

module controller (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cpu_pkg::cond_e         cond,
    input  logic                   is_dp,
    input  logic                   is_mem,
    input  logic                   is_br,
    input  cpu_pkg::alu_op_e       alu_op,
    input  logic                   en_status_decode,
    input  logic                   imm_op,
    input  logic                   p,
    input  logic                   w,
    input  logic                   l,
    input  logic [`CPU_DATA_W-1:0] status_reg,
    output logic                   waiting,
    output logic                   load_ir,
    output logic                   load_pc,
    output logic [1:0]             sel_pc,
    output logic                   en_a,
    output logic                   en_b,
    output logic                   en_c,
    output logic                   sel_b_imm,
    output logic                   sel_pre_indexed,
    output logic                   en_status,
    output logic                   w_en1,
    output logic                   w_en_ldr,
    output logic                   w_en_base,
    output logic                   ram_w_en2
);
    import cpu_pkg::*;

    localparam logic [3:0] S_START    = 4'd0;
    localparam logic [3:0] S_FETCH    = 4'd1;
    localparam logic [3:0] S_LOAD_IR  = 4'd2;
    localparam logic [3:0] S_DECODE   = 4'd3;
    localparam logic [3:0] S_EXEC     = 4'd4;
    localparam logic [3:0] S_MEM      = 4'd5;
    localparam logic [3:0] S_MEM_WAIT = 4'd6;
    localparam logic [3:0] S_WB       = 4'd7;
    localparam logic [3:0] S_HALT     = 4'd8;

    logic [3:0] state, state_nxt;
    logic       pass;

    function automatic logic cond_pass(input cond_e cc, input logic [`CPU_DATA_W-1:0] st);
        logic n, z, c, v;
        n = st[ST_N];
        z = st[ST_Z];
        c = st[ST_C];
        v = st[ST_V];
        case (cc)
            COND_EQ: return z;
            COND_NE: return !z;
            COND_CS: return c;
            COND_CC: return !c;
            COND_MI: return n;
            COND_PL: return !n;
            COND_VS: return v;
            COND_VC: return !v;
            COND_HI: return c && !z;
            COND_LS: return !c || z;
            COND_GE: return n == v;
            COND_LT: return n != v;
            COND_GT: return !z && (n == v);
            COND_LE: return z || (n != v);
            COND_AL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    assign pass = cond_pass(cond, status_reg);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_START;
            ram_w_en2 <= 1'b0;
        end else begin
            state     <= state_nxt;
            ram_w_en2 <= (state == S_EXEC) && is_mem && !l;  // high for the whole S_MEM cycle
        end
    end

    always_comb begin
        state_nxt = state;
        load_ir   = 1'b0;
        load_pc   = 1'b0;
        sel_pc    = PC_SEL_INC;
        en_a      = 1'b0;
        en_b      = 1'b0;
        en_c      = 1'b0;
        en_status = 1'b0;
        w_en1     = 1'b0;
        w_en_ldr  = 1'b0;
        w_en_base = 1'b0;
        case (state)
            S_START: begin
                load_pc   = 1'b1;
                sel_pc    = PC_SEL_START;
                state_nxt = S_FETCH;
            end
            S_FETCH:   state_nxt = S_LOAD_IR;  // imem sees pc_out
            S_LOAD_IR: begin
                load_ir   = 1'b1;
                state_nxt = S_DECODE;
            end
            S_DECODE: begin
                if (cond == COND_HALT) begin
                    state_nxt = S_HALT;
                end else if (!pass || is_br) begin
                    load_pc   = 1'b1;
                    sel_pc    = pass ? PC_SEL_BR : PC_SEL_INC;
                    state_nxt = S_FETCH;
                end else begin
                    en_a      = 1'b1;
                    en_b      = 1'b1;
                    state_nxt = S_EXEC;
                end
            end
            S_EXEC: begin
                en_c = 1'b1;
                if (is_mem) begin
                    state_nxt = S_MEM;
                end else begin
                    w_en1     = is_dp && (alu_op != ALU_CMP);
                    en_status = is_dp && en_status_decode;
                    load_pc   = 1'b1;
                    state_nxt = S_FETCH;
                end
            end
            S_MEM:      state_nxt = S_MEM_WAIT;
            S_MEM_WAIT: begin
                w_en_ldr  = l;  // load data valid now
                state_nxt = S_WB;
            end
            S_WB: begin
                w_en_base = w || !p;
                load_pc   = 1'b1;
                state_nxt = S_FETCH;
            end
            S_HALT:  state_nxt = S_HALT;
            default: state_nxt = S_START;
        endcase
    end

    assign waiting         = state == S_HALT;
    assign sel_b_imm       = imm_op || is_mem;
    assign sel_pre_indexed = !is_mem || p;  // post-indexed uses the bare base

endmodule

`default_nettype wire

// ==== src/idecoder.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cpu_settings.svh"

module idecoder (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`CPU_DATA_W-1:0]        instr,
    input  logic                          load_ir,
    output cpu_pkg::cond_e                cond,
    output logic                          is_dp,
    output logic                          is_mem,
    output logic                          is_br,
    output cpu_pkg::alu_op_e              alu_op,
    output logic                          en_status_decode,
    output logic                          imm_op,
    output logic [$clog2(`CPU_NREGS)-1:0] rn,
    output logic [$clog2(`CPU_NREGS)-1:0] rd,
    output logic [$clog2(`CPU_NREGS)-1:0] rm,
    output cpu_pkg::shift_e               shift_op,
    output logic [4:0]                    imm5,
    output logic [11:0]                   imm12,
    output logic [23:0]                   imm24,
    output logic                          p,
    output logic                          w,
    output logic                          l
);
    import cpu_pkg::*;

    instr_u ir;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else if (load_ir) begin
            ir <= instr;
        end
    end

    assign cond   = ir.dp.cond;  // same bits in every view
    assign is_dp  = ir.dp.cls == CLS_DP;
    assign is_mem = ir.dp.cls == CLS_MEM;
    assign is_br  = ir.dp.cls == CLS_BR;

    // memory ops reuse the adder, u picks the direction
    assign alu_op = is_mem ? (ir.mem.u ? ALU_ADD : ALU_SUB) : ir.dp.opcode;
    assign en_status_decode = ir.dp.s || (ir.dp.opcode == ALU_CMP);
    assign imm_op = ir.dp.i;

    assign rn       = ir.dp.rn;  // same position in the memory view
    assign rd       = ir.dp.rd;
    assign rm       = ir.dp.op2.rs.rm;
    assign shift_op = ir.dp.op2.rs.shift_op;
    assign imm5     = ir.dp.op2.rs.imm5;
    assign imm12    = ir.dp.op2.imm12;
    assign imm24    = ir.br.imm24;

    assign p = ir.mem.p;
    assign w = ir.mem.w;
    assign l = ir.mem.l;

endmodule

`default_nettype wire

// ==== src/cpu.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cpu_settings.svh"

module cpu (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`CPU_DATA_W-1:0]        instr,
    input  logic [`CPU_DATA_W-1:0]        ram_data2,
    input  logic [`CPU_ADDR_W-1:0]        start_pc,
    input  logic [$clog2(`CPU_NREGS)-1:0] reg_addr,
    output logic                          waiting,
    output logic                          ram_w_en2,
    output logic [`CPU_ADDR_W-1:0]        ram_addr2,
    output logic [`CPU_DATA_W-1:0]        ram_in2,
    output logic [`CPU_DATA_W-1:0]        status_out,
    output logic [`CPU_DATA_W-1:0]        datapath_out,
    output logic [`CPU_ADDR_W-1:0]        pc_out,
    output logic [`CPU_DATA_W-1:0]        reg_output
);
    import cpu_pkg::*;

    localparam int RW = $clog2(`CPU_NREGS);

    // decoder fields
    cond_e   cond;
    alu_op_e alu_op;
    shift_e  shift_op;
    logic    is_dp, is_mem, is_br;
    logic    en_status_decode, imm_op;
    logic    p, w, l;
    logic [RW-1:0] rn, rd, rm;
    logic [4:0]    imm5;
    logic [11:0]   imm12;
    logic [23:0]   imm24;

    // controller strobes
    logic       load_ir, load_pc;
    logic [1:0] sel_pc;
    logic       en_a, en_b, en_c;
    logic       sel_b_imm, sel_pre_indexed, en_status;
    logic       w_en1, w_en_ldr, w_en_base;

    idecoder i_idecoder (
        .clk, .arst_n, .instr, .load_ir,
        .cond, .is_dp, .is_mem, .is_br, .alu_op, .en_status_decode, .imm_op,
        .rn, .rd, .rm, .shift_op, .imm5, .imm12, .imm24, .p, .w, .l
    );

    controller i_controller (
        .clk, .arst_n, .cond, .is_dp, .is_mem, .is_br, .alu_op,
        .en_status_decode, .imm_op, .p, .w, .l,
        .status_reg (status_out),
        .waiting, .load_ir, .load_pc, .sel_pc, .en_a, .en_b, .en_c,
        .sel_b_imm, .sel_pre_indexed, .en_status,
        .w_en1, .w_en_ldr, .w_en_base, .ram_w_en2
    );

    datapath i_datapath (
        .clk, .arst_n, .start_pc, .load_pc, .sel_pc, .rn, .rd, .rm,
        .imm5, .shift_op,
        .imm12 ({{(`CPU_DATA_W-12){1'b0}}, imm12}),  // zero-extended
        .imm24, .alu_op, .en_a, .en_b, .en_c, .sel_b_imm, .sel_pre_indexed,
        .en_status, .w_en1, .w_en_ldr, .w_en_base, .ram_data2, .reg_addr,
        .pc_out, .datapath_out, .ram_addr2, .ram_in2, .status_out, .reg_output
    );

endmodule

`default_nettype wire

// ==== dv/cpu_checker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_checker (
    input wire logic                   clk,
    input wire logic                   arst_n,
    input wire logic                   waiting,
    input wire logic                   ram_w_en2,
    input wire logic [`CPU_ADDR_W-1:0] ram_addr2,
    input wire logic [`CPU_DATA_W-1:0] ram_in2,
    input wire logic [`CPU_DATA_W-1:0] status_out,
    input wire logic [`CPU_DATA_W-1:0] datapath_out,
    input wire logic [`CPU_ADDR_W-1:0] pc_out,
    input wire logic [`CPU_DATA_W-1:0] reg_output
);
    localparam int DEPTH = 1 << `CPU_ADDR_W;

    logic [31:0] imem_m [DEPTH];
    logic [31:0] dmem_m [DEPTH];
    logic [31:0] regs_m [16];
    logic [3:0]  nzcv_m;
    logic [10:0] halt_pc_m;
    logic [10:0] st_addr_q [$];
    logic [31:0] st_data_q [$];
    logic [31:0] st_ea_q [$];
    logic [10:0] exp_addr;
    logic [31:0] exp_data;
    logic [31:0] exp_ea;
    int          mismatches = 0;
    int          other_errors = 0;

    task automatic report_mismatch(input string name, input logic [31:0] got, exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        mismatches++;
    endtask

    task automatic load_word(input logic [10:0] addr, input logic [31:0] iw, dw);
        imem_m[addr] = iw;
        dmem_m[addr] = dw;
    endtask

    function automatic logic cond_ok(input logic [3:0] cc, input logic [3:0] f);
        logic n, z, c, v;
        {n, z, c, v} = f;
        case (cc)
            4'd0:  return z;
            4'd1:  return !z;
            4'd2:  return c;
            4'd3:  return !c;
            4'd4:  return n;
            4'd5:  return !n;
            4'd6:  return v;
            4'd7:  return !v;
            4'd8:  return c && !z;
            4'd9:  return !c || z;
            4'd10: return n == v;
            4'd11: return n != v;
            4'd12: return !z && (n == v);
            4'd13: return z || (n != v);
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] shift_val(input logic [31:0] x, input logic [1:0] kind,
                                              input logic [4:0] amt);
        case (kind)
            2'd0: return x << amt;
            2'd1: return x >> amt;
            2'd2: return 32'($signed(x) >>> amt);
            default: return (amt == 5'd0) ? x : ((x >> amt) | (x << (6'd32 - {1'b0, amt})));
        endcase
    endfunction

    task automatic exec_dp(input logic [31:0] w);
        logic [31:0] a, b, r;
        logic [32:0] wide;
        logic [2:0]  op;
        logic        c, v;
        op = w[24:22];
        c = 1'b0;
        v = 1'b0;
        a = regs_m[w[19:16]];
        b = w[25] ? {20'b0, w[11:0]} : shift_val(regs_m[w[3:0]], w[6:5], w[11:7]);
        case (op)
            3'd0: begin
                wide = {1'b0, a} + {1'b0, b};
                r = wide[31:0];
                c = wide[32];
                v = (a[31] == b[31]) && (r[31] != a[31]);
            end
            3'd1, 3'd6: begin
                r = a - b;
                c = a >= b;  // no borrow
                v = (a[31] != b[31]) && (r[31] != a[31]);
            end
            3'd2: r = a & b;
            3'd3: r = a | b;
            3'd4: r = a ^ b;
            default: r = b;
        endcase
        if (w[21] || op == 3'd6) begin
            if (op == 3'd0 || op == 3'd1 || op == 3'd6)
                nzcv_m = {r[31], r == 32'd0, c, v};
            else
                nzcv_m = {r[31], r == 32'd0, nzcv_m[1:0]};
        end
        if (op != 3'd6)
            regs_m[w[15:12]] = r;
    endtask

    task automatic run_model(input logic [10:0] start);
        logic [10:0] pc, addr;
        logic [31:0] w, base, sum;
        int          steps;
        logic        done;
        pc = start;
        nzcv_m = 4'b0;
        st_addr_q.delete();
        st_data_q.delete();
        st_ea_q.delete();
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            w = imem_m[pc];
            steps++;
            if (w[31:28] == 4'hf) begin
                halt_pc_m = pc;
                done = 1'b1;
            end else if (!cond_ok(w[31:28], nzcv_m)) begin
                pc = pc + 11'd1;
            end else if (w[27:26] == 2'b10) begin
                pc = pc + 11'd1 + w[10:0];  // wraps in 11 bits
            end else if (w[27:26] == 2'b01) begin
                base = regs_m[w[19:16]];
                sum = w[24] ? base + {20'b0, w[11:0]} : base - {20'b0, w[11:0]};
                addr = w[25] ? sum[10:0] : base[10:0];
                if (w[20]) begin
                    regs_m[w[15:12]] = dmem_m[addr];
                end else begin
                    st_addr_q.push_back(addr);
                    st_data_q.push_back(regs_m[w[15:12]]);
                    st_ea_q.push_back(w[25] ? sum : base);  // untruncated address
                    dmem_m[addr] = regs_m[w[15:12]];
                end
                if (w[21] || !w[25])
                    regs_m[w[19:16]] = sum;
                pc = pc + 11'd1;
            end else begin
                exec_dp(w);
                pc = pc + 11'd1;
            end
        end
        if (!done) begin
            $display("model ran 1000 steps without reaching HALT");
            other_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (arst_n && ram_w_en2) begin
            if (st_addr_q.size() == 0) begin
                $display("unexpected store at %0t to address %h", $time, ram_addr2);
                other_errors++;
            end else begin
                exp_addr = st_addr_q.pop_front();
                exp_data = st_data_q.pop_front();
                exp_ea   = st_ea_q.pop_front();
                if (ram_addr2 !== exp_addr)
                    report_mismatch("ram_addr2", {21'b0, ram_addr2}, {21'b0, exp_addr});
                if (ram_in2 !== exp_data)
                    report_mismatch("ram_in2", ram_in2, exp_data);
                if (datapath_out !== exp_ea)
                    report_mismatch("datapath_out", datapath_out, exp_ea);
            end
        end
    end

    task automatic check_reset(input logic [10:0] start);
        if (waiting !== 1'b0 || ram_w_en2 !== 1'b0) begin
            $display("waiting or ram_w_en2 not low after reset at %0t", $time);
            other_errors++;
        end
        if (pc_out !== start)
            report_mismatch("pc_out", {21'b0, pc_out}, {21'b0, start});
    endtask

    task automatic check_reg(input int k);
        if (reg_output !== regs_m[k])
            report_mismatch($sformatf("r%0d", k), reg_output, regs_m[k]);
    endtask

    task automatic check_halt();
        if (status_out !== {nzcv_m, 28'b0})
            report_mismatch("status_out", status_out, {nzcv_m, 28'b0});
        if (pc_out !== halt_pc_m)
            report_mismatch("pc_out", {21'b0, pc_out}, {21'b0, halt_pc_m});
        if (st_addr_q.size() != 0) begin
            $display("%0d expected stores never happened", st_addr_q.size());
            other_errors++;
        end
    endtask

endmodule

`default_nettype wire

// ==== dv/cpu_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_asserts (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic waiting,
    input wire logic load_ir,
    input wire logic ram_w_en2
);

    // no stores once halted
    store_while_halted: assert property (
        @(posedge clk) disable iff (!arst_n) waiting |-> !ram_w_en2
    ) else $error("store strobe high while core is halted");

    // halt is terminal until reset
    halt_is_sticky: assert property (
        @(posedge clk) disable iff (!arst_n) !$fell(waiting)
    ) else $error("waiting fell without a reset");

    ir_load_vs_store: assert property (
        @(posedge clk) disable iff (!arst_n) !(load_ir && ram_w_en2)
    ) else $error("instruction load and store strobe high together");

endmodule

bind controller cpu_asserts i_cpu_asserts (
    .clk       (clk),
    .arst_n    (arst_n),
    .waiting   (waiting),
    .load_ir   (load_ir),
    .ram_w_en2 (ram_w_en2)
);

`default_nettype wire

// ==== dv/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_tb;
    localparam int DEPTH = 1 << `CPU_ADDR_W;
    localparam int NPROG = 20;
    localparam int NINIT = 16;  // MOVs so that no register starts unknown
    localparam int NRAND = 60;
    localparam int PLEN  = NINIT + NRAND + 1;
    localparam longint WATCHDOG_NS = 64'(NPROG) * 64'(PLEN * 100 + 40) * 64'd40;

    logic        clk, arst_n;
    logic [31:0] instr, ram_data2;
    logic [10:0] start_pc;
    logic [3:0]  reg_addr;
    wire logic        waiting, ram_w_en2;
    wire logic [10:0] ram_addr2, pc_out;
    wire logic [31:0] ram_in2, status_out, datapath_out, reg_output;

    logic [31:0] imem [DEPTH];
    logic [31:0] dmem [DEPTH];
    int          errs;

    cpu i_cpu (
        .clk, .arst_n, .instr, .ram_data2, .start_pc, .reg_addr,
        .waiting, .ram_w_en2, .ram_addr2, .ram_in2, .status_out,
        .datapath_out, .pc_out, .reg_output
    );

    cpu_checker i_checker (
        .clk, .arst_n, .waiting, .ram_w_en2, .ram_addr2, .ram_in2,
        .status_out, .datapath_out, .pc_out, .reg_output
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: core did not halt within the allowed time");
        $display("Test failed");
        $finish;
    end

    // memories answer one cycle after the address
    always @(negedge clk) begin
        instr     <= imem[pc_out];
        ram_data2 <= dmem[ram_addr2];
        if (ram_w_en2)
            dmem[ram_addr2] <= ram_in2;
    end

    task automatic build_program(input logic [10:0] base);
        logic [31:0] w;
        logic [11:0] op2;
        logic [3:0]  cond, rn, rd;
        logic        p, u, wb, l;
        int          kind, off;
        for (int a = 0; a < DEPTH; a++) begin
            imem[a] = {4'hf, 17'b0, 11'(a)};  // stray fetch halts
            dmem[a] = $urandom;
        end
        for (int k = 0; k < NINIT; k++)
            imem[11'(base + k)] = {4'he, 2'b00, 1'b1, 3'd5, 2'b00, 4'd0, 4'(k), 12'($urandom)};
        for (int idx = NINIT; idx < NINIT + NRAND; idx++) begin
            cond = 4'($urandom_range(0, 14));
            rn   = 4'($urandom);
            rd   = 4'($urandom);
            kind = $urandom_range(0, 9);
            if (kind < 6) begin
                op2 = 12'($urandom);
                p = 1'($urandom);  // immediate select
                if (!p)
                    op2[4] = 1'b0;
                w = {cond, 2'b00, p, 3'($urandom_range(0, 6)), 1'($urandom), 1'b0, rn, rd, op2};
            end else if (kind < 8) begin
                {p, u, wb, l} = 4'($urandom);
                if (l && (wb || !p) && rd == rn)
                    rd = rn + 4'd1;
                w = {cond, 2'b01, p, u, 2'b00, wb, l, rn, rd, 12'($urandom)};
            end else begin
                off = $urandom_range(0, PLEN - 2 - idx);  // forward, at most to HALT
                w = {cond, 2'b10, 2'b00, 24'(off)};
            end
            imem[11'(base + idx)] = w;
        end
        imem[11'(base + PLEN - 1)] = {4'hf, 28'b0};
        for (int a = 0; a < DEPTH; a++)
            i_checker.load_word(11'(a), imem[a], dmem[a]);
    endtask

    initial begin
        arst_n    = 1'b0;
        instr     = '0;
        ram_data2 = '0;
        start_pc  = '0;
        reg_addr  = '0;
        void'($urandom(32'h1ed59270));
        for (int prog = 0; prog < NPROG; prog++) begin
            @(negedge clk);
            arst_n   = 1'b0;
            start_pc = 11'($urandom);
            build_program(start_pc);
            i_checker.run_model(start_pc);
            repeat (8) @(negedge clk);
            arst_n = 1'b1;
            @(posedge clk);
            @(negedge clk);
            i_checker.check_reset(start_pc);
            while (!waiting)
                @(negedge clk);
            for (int k = 0; k < 16; k++) begin
                @(negedge clk);
                reg_addr = 4'(k);
                @(posedge clk);
                i_checker.check_reg(k);
            end
            i_checker.check_halt();
        end
        errs = i_checker.mismatches + i_checker.other_errors;
        $display("errors: %0d mismatches, %0d other failures",
                 i_checker.mismatches, i_checker.other_errors);
        if (errs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu.f ====
+incdir+common
common/cpu_pkg.sv
datapath/alu_shifter.sv
datapath/datapath.sv
controller/controller.sv
src/idecoder.sv
src/cpu.sv
dv/cpu_checker.sv
dv/cpu_asserts.sv
dv/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -Icommon \
    --top-module cpu_tb -f cpu.f -o cpu_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/cpu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
